/* Bender.yml */
package:
  name: soc_bus_fabric

sources:
  - files:
      - verilog/bus_pkg.sv
      - verilog/soc_map_pkg.sv
      - verilog/reset_debounce.sv
      - verilog/wb_addr_decode.sv
      - verilog/wb_slave_mux.sv
      - verilog/int_ack_return.sv
      - verilog/soc_bus_fabric.sv
  - target: test
    files:
      - verification/tb_soc_bus_fabric.sv

/* compile.f */
verilog/bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/reset_debounce.sv
verilog/wb_addr_decode.sv
verilog/wb_slave_mux.sv
verilog/int_ack_return.sv
verilog/soc_bus_fabric.sv
verification/tb_soc_bus_fabric.sv

/* verification/tb_soc_bus_fabric.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_soc_bus_fabric
  import bus_pkg::*, soc_map_pkg::*;
();

  localparam logic [3:0] NO_SLAVE = 4'hF;  // Default responder expected

  // One bus access and what should come back
  typedef struct packed {
    logic       tga;
    logic [19:0] addr;  // Byte address
    logic       we;
    bus_sel_t   sel;
    logic [3:0] slave;
    bus_data_t  dat;
  } row_t;

  logic                  clk;
  logic                  rst_lck;
  wb_req_t               cpu_req;
  wb_rsp_t               cpu_rsp;
  logic [7:0]            intv;
  logic                  inta;
  logic                  nmia;
  logic                  intr;
  wb_req_t [N_SLAVES-1:0] slv_req;
  wb_rsp_t [N_SLAVES-1:0] slv_rsp;
  logic                  rst_o;

  row_t   rows [$];
  string  names [$];
  int     errors = 0;
  int     checks = 0;
  int     cycles = 0;
  int     limit;
  integer seed = 73589;

  logic [N_SLAVES-1:0] ack_q = '0;
  int                  wait_q [N_SLAVES] = '{default: 0};

  soc_bus_fabric #(
    .DEBOUNCE_BITS (3)
  ) i_dut (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .cpu_req_i (cpu_req),
    .cpu_rsp_o (cpu_rsp),
    .intv_i    (intv),
    .inta_i    (inta),
    .nmia_i    (nmia),
    .intr_o    (intr),
    .slv_req_o (slv_req),
    .slv_rsp_i (slv_rsp),
    .rst_o     (rst_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Slave models with random ack latency of 1 to 3 cycles
  always @(posedge clk) begin
    int delay;
    for (int k = 0; k < N_SLAVES; k++) begin
      if (ack_q[k]) begin
        ack_q[k] <= 1'b0;
      end else if (wait_q[k] != 0) begin
        if (wait_q[k] == 1) begin
          ack_q[k] <= 1'b1;
        end
        wait_q[k] <= wait_q[k] - 1;
      end else if (slv_req[k].cyc && slv_req[k].stb) begin
        delay = 1 + ($unsigned($random(seed)) % 3);
        if (delay == 1) begin
          ack_q[k] <= 1'b1;
        end else begin
          wait_q[k] <= delay - 1;
        end
      end
    end
  end

  always_comb begin
    for (int k = 0; k < N_SLAVES; k++) begin
      slv_rsp[k].dat = 16'hA500 + 16'(k);  // Tags the answering slave
      slv_rsp[k].ack = ack_q[k];
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles, an access or the run never completed", cycles);
      $display("Checks %0d, errors %0d", checks, errors + 1);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic slave_sel_t strobe_vector();
    slave_sel_t v;
    for (int k = 0; k < N_SLAVES; k++) begin
      v[k] = slv_req[k].stb;
    end
    return v;
  endfunction

  task automatic check_sel(input string name, input slave_sel_t exp, input slave_sel_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_req(input string name, input wb_req_t exp, input wb_req_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected req %h, actual req %h", name, exp, act);
    end
  endtask

  task automatic check_rsp(input string name, input wb_rsp_t exp, input wb_rsp_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected dat %h ack %b, actual dat %h ack %b",
               name, exp.dat, exp.ack, act.dat, act.ack);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic add_row(input string name, input logic tga, input logic [19:0] addr,
                         input logic we, input bus_sel_t sel, input logic [3:0] slave,
                         input bus_data_t dat);
    row_t r;
    r = '{tga: tga, addr: addr, we: we, sel: sel, slave: slave, dat: dat};
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic run_access(input int r);
    row_t       row;
    slave_sel_t exp_sel;
    wb_rsp_t    exp_rsp;
    row = rows[r];
    exp_sel = '0;
    if (row.slave != NO_SLAVE) begin
      exp_sel[row.slave] = 1'b1;
    end
    exp_rsp.dat = row.dat;
    exp_rsp.ack = (row.slave == NO_SLAVE);  // Only the default responder acks at once
    @(negedge clk);
    cpu_req.adr = row.addr[19:1];
    cpu_req.tga = row.tga;
    cpu_req.we  = row.we;
    cpu_req.sel = row.sel;
    cpu_req.dat = 16'h1200 + 16'(r);
    cpu_req.cyc = 1'b1;
    cpu_req.stb = 1'b1;
    #10;
    check_sel(names[r], exp_sel, strobe_vector());
    if (row.slave != NO_SLAVE) begin
      check_req(names[r], cpu_req, slv_req[row.slave]);  // Routed slave sees the whole access
    end
    check_rsp(names[r], exp_rsp, cpu_rsp);
    while (!cpu_rsp.ack) begin
      @(negedge clk);
    end
    exp_rsp.ack = 1'b1;
    check_rsp(names[r], exp_rsp, cpu_rsp);
    @(negedge clk);
    cpu_req = '0;
  endtask

  initial begin
    wb_rsp_t vec_rsp;
    rst_lck = 1'b0;
    intv    = '0;
    inta    = 1'b0;
    nmia    = 1'b0;
    cpu_req     = '0;
    cpu_req.adr = 19'h091A0;  // RAM read held through reset
    cpu_req.cyc = 1'b1;
    cpu_req.stb = 1'b1;

    add_row("rom_read",     1'b0, 20'hFFE00, 1'b0, 2'b11, 4'(SLV_ROM),   16'hA500);
    add_row("vga_mem",      1'b0, 20'hB8000, 1'b1, 2'b11, 4'(SLV_VGA),   16'hA501);
    add_row("ram_read",     1'b0, 20'h12340, 1'b0, 2'b11, 4'(SLV_RAM),   16'hA506);
    add_row("ram_write",    1'b0, 20'h12340, 1'b1, 2'b01, 4'(SLV_RAM),   16'hA506);
    add_row("vga_io",       1'b1, 20'h003C4, 1'b1, 2'b01, 4'(SLV_VGA),   16'hA501);
    add_row("uart_io",      1'b1, 20'h003F8, 1'b0, 2'b01, 4'(SLV_UART),  16'hA502);
    add_row("keyb_60",      1'b1, 20'h00060, 1'b0, 2'b01, 4'(SLV_KEYB),  16'hA503);
    add_row("keyb_64",      1'b1, 20'h00064, 1'b0, 2'b01, 4'(SLV_KEYB),  16'hA503);
    add_row("gpio_io",      1'b1, 20'h0F102, 1'b1, 2'b01, 4'(SLV_GPIO),  16'hA504);
    add_row("timer_io",     1'b1, 20'h00040, 1'b0, 2'b01, 4'(SLV_TIMER), 16'hA505);
    add_row("spk_61",       1'b1, 20'h00061, 1'b1, 2'b10, 4'(SLV_SPK),   16'hA507);
    add_row("unmapped_300", 1'b1, 20'h00300, 1'b0, 2'b01, NO_SLAVE,      16'h0000);
    limit = rows.size() * 8 + 200;

    // Reset hold, nothing may reach a slave
    repeat (4) begin
      @(negedge clk);
      check_bit("rst_asserted", 1'b1, rst_o);
      check_sel("reset_stb", '0, strobe_vector());
    end
    rst_lck = 1'b1;
    for (int i = 1; i <= 7; i++) begin
      @(negedge clk);
      check_bit("rst_hold", 1'b1, rst_o);
      check_sel("reset_stb", '0, strobe_vector());
    end
    cpu_req = '0;
    @(negedge clk);
    check_bit("rst_release", 1'b0, rst_o);

    for (int r = 0; r < rows.size(); r++) begin
      run_access(r);
    end

    // Interrupt edges on lines 1 and 4
    @(negedge clk);
    check_bit("intr_idle", 1'b0, intr);
    intv = 8'b0001_0010;
    #10;
    check_bit("intr_not_yet", 1'b0, intr);
    @(negedge clk);
    check_bit("intr_raise", 1'b1, intr);
    inta = 1'b1;
    #10;
    vec_rsp = '{dat: 16'h0009, ack: 1'b0};
    check_rsp("inta_first", vec_rsp, cpu_rsp);
    @(negedge clk);
    inta = 1'b0;
    @(negedge clk);
    check_bit("intr_still_pending", 1'b1, intr);
    inta = 1'b1;
    #10;
    vec_rsp = '{dat: 16'h000C, ack: 1'b0};
    check_rsp("inta_second", vec_rsp, cpu_rsp);
    @(negedge clk);
    inta = 1'b0;
    @(negedge clk);
    check_bit("intr_cleared", 1'b0, intr);
    nmia = 1'b1;
    #10;
    vec_rsp = '{dat: 16'h0002, ack: 1'b0};
    check_rsp("nmia_vector", vec_rsp, cpu_rsp);
    @(negedge clk);
    nmia = 1'b0;
    @(negedge clk);

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/bus_pkg.sv */
`default_nettype none

package bus_pkg;

  // Processor bus geometry, 8086 style word bus
  localparam int unsigned DATA_W = 16;
  localparam int unsigned ADDR_W = 19;  // Word address, byte bit 0 folded into sel
  localparam int unsigned SEL_W  = 2;

  typedef logic [DATA_W-1:0] bus_data_t;
  typedef logic [ADDR_W-1:0] bus_addr_t;  // Holds byte address bits 19:1
  typedef logic [SEL_W-1:0]  bus_sel_t;

  // Master to slave, held stable until ack
  typedef struct packed {
    bus_addr_t adr;
    logic      tga;  // 1 for I/O space
    logic      we;
    bus_sel_t  sel;
    bus_data_t dat;
    logic      cyc;
    logic      stb;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    bus_data_t dat;
    logic      ack;  // One cycle per completed access
  } wb_rsp_t;

endpackage

`default_nettype wire

/* verilog/int_ack_return.sv */
`timescale 1ns/10ps
`default_nettype none

module int_ack_return
  import bus_pkg::*, soc_map_pkg::*;
(
  input  wire        clk,
  input  wire        rst_i,
  input  wire  [7:0] intv_i,
  input  wire        inta_i,
  input  wire        nmia_i,
  output logic       intr_o,
  input  wb_rsp_t    rsp_i,
  output wb_rsp_t    rsp_o
);

  logic [7:0] intv_q;
  logic [7:0] pending;
  logic [7:0] clr_mask;
  logic       inta_q;
  logic [2:0] iid;
  logic [2:0] iid_q;  // Vector in service

  // Lowest index has priority
  always_comb begin
    iid = '0;
    for (int n = 7; n >= 0; n--) begin
      if (pending[n]) begin
        iid = 3'(n);
      end
    end
  end

  // Clear on the falling edge of inta
  always_comb begin
    clr_mask = '0;
    if (inta_q && !inta_i) begin
      clr_mask[iid_q] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      intv_q  <= '0;
      pending <= '0;
      inta_q  <= 1'b0;
    end else begin
      intv_q  <= intv_i;
      inta_q  <= inta_i;
      pending <= (pending & ~clr_mask) | (intv_i & ~intv_q);
    end
  end

  always_ff @(posedge clk) begin
    if (inta_i) begin
      iid_q <= iid;
    end
  end

  assign intr_o = |pending;

  // NMI acknowledge wins over INTA
  always_comb begin
    rsp_o.ack = rsp_i.ack;
    if (nmia_i) begin
      rsp_o.dat = NMI_VECTOR;
    end else if (inta_i) begin
      rsp_o.dat = INT_VECTOR_BASE + bus_data_t'(iid);
    end else begin
      rsp_o.dat = rsp_i.dat;
    end
  end

endmodule

`default_nettype wire

/* verilog/reset_debounce.sv */
`timescale 1ns/10ps
`default_nettype none

module reset_debounce #(
  parameter int unsigned DEBOUNCE_BITS = 17
) (
  input  wire  clk,
  input  wire  rst_lck,
  output logic rst_o
);

  // Both start asserted so the system comes up in reset
  logic [DEBOUNCE_BITS-1:0] cnt   = '1;
  logic                     rst_q = 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt <= '1;  // Any bounce restarts the hold
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
    rst_q <= (cnt != '0);
  end

  assign rst_o = rst_q;

endmodule

`default_nettype wire

/* verilog/soc_bus_fabric.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_bus_fabric
  import bus_pkg::*, soc_map_pkg::*;
#(
  parameter int unsigned DEBOUNCE_BITS = 17
) (
  input  wire                      clk,
  input  wire                      rst_lck,
  input  wb_req_t                  cpu_req_i,
  output wb_rsp_t                  cpu_rsp_o,
  input  wire  [7:0]               intv_i,
  input  wire                      inta_i,
  input  wire                      nmia_i,
  output logic                     intr_o,
  output wb_req_t [N_SLAVES-1:0]   slv_req_o,
  input  wb_rsp_t [N_SLAVES-1:0]   slv_rsp_i,
  output logic                     rst_o
);

  slave_sel_t sel;
  logic       hit;
  wb_rsp_t    mux_rsp;  // Before vector substitution

  reset_debounce #(
    .DEBOUNCE_BITS (DEBOUNCE_BITS)
  ) i_reset_debounce (
    .clk     (clk),
    .rst_lck (rst_lck),
    .rst_o   (rst_o)
  );

  wb_addr_decode i_wb_addr_decode (
    .req_i (cpu_req_i),
    .sel_o (sel),
    .hit_o (hit)
  );

  wb_slave_mux i_wb_slave_mux (
    .rst_i     (rst_o),
    .req_i     (cpu_req_i),
    .sel_i     (sel),
    .hit_i     (hit),
    .slv_req_o (slv_req_o),
    .slv_rsp_i (slv_rsp_i),
    .rsp_o     (mux_rsp)
  );

  int_ack_return i_int_ack_return (
    .clk    (clk),
    .rst_i  (rst_o),
    .intv_i (intv_i),
    .inta_i (inta_i),
    .nmia_i (nmia_i),
    .intr_o (intr_o),
    .rsp_i  (mux_rsp),
    .rsp_o  (cpu_rsp_o)
  );

endmodule

`default_nettype wire

/* verilog/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

  import bus_pkg::*;

  localparam int unsigned N_SLAVES = 8;

  typedef logic [N_SLAVES-1:0] slave_sel_t;  // One-hot

  localparam int unsigned SLV_ROM   = 0;
  localparam int unsigned SLV_VGA   = 1;
  localparam int unsigned SLV_UART  = 2;
  localparam int unsigned SLV_KEYB  = 3;
  localparam int unsigned SLV_GPIO  = 4;
  localparam int unsigned SLV_TIMER = 5;
  localparam int unsigned SLV_RAM   = 6;
  localparam int unsigned SLV_SPK   = 7;

  // Match and mask, both laid out as {tga, adr[19:1]}
  typedef struct packed {
    logic [ADDR_W:0] match;
    logic [ADDR_W:0] mask;
  } win_t;

  localparam int unsigned N_WINDOWS = 9;
  localparam int unsigned WIN_SPK   = 8;  // Refines the keyboard window, not decoded

  // First match wins
  localparam win_t WINDOWS [N_WINDOWS] = '{
    '{match: {1'b0, 19'h7FF00}, mask: {1'b1, 19'h7FF00}},  // FFE00-FFFFF boot ROM
    '{match: {1'b0, 19'h50000}, mask: {1'b1, 19'h70000}},  // A0000-BFFFF frame buffer
    '{match: {1'b1, 19'h001E0}, mask: {1'b1, 19'h07FF0}},  // io 3C0-3DF
    '{match: {1'b1, 19'h001FC}, mask: {1'b1, 19'h07FFC}},  // io 3F8-3FF COM1
    '{match: {1'b1, 19'h00030}, mask: {1'b1, 19'h07FFD}},  // io 60, 64
    '{match: {1'b1, 19'h07880}, mask: {1'b1, 19'h07FFE}},  // io F100-F103
    '{match: {1'b1, 19'h00020}, mask: {1'b1, 19'h07FFE}},  // io 40-43
    '{match: {1'b0, 19'h00000}, mask: {1'b1, 19'h00000}},  // Rest of memory
    '{match: {1'b1, 19'h00030}, mask: {1'b1, 19'h07FFF}}   // io 61 high byte
  };

  localparam int unsigned WIN_SLAVE [N_WINDOWS] = '{
    SLV_ROM, SLV_VGA, SLV_VGA, SLV_UART, SLV_KEYB,
    SLV_GPIO, SLV_TIMER, SLV_RAM, SLV_SPK
  };

  // Data placed on the bus during acknowledge cycles
  localparam bus_data_t NMI_VECTOR      = 16'h0002;
  localparam bus_data_t INT_VECTOR_BASE = 16'd8;

endpackage

`default_nettype wire

/* verilog/wb_addr_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_addr_decode
  import bus_pkg::*, soc_map_pkg::*;
(
  input  wb_req_t    req_i,
  output slave_sel_t sel_o,
  output logic       hit_o
);

  logic [ADDR_W:0] key;

  assign key = {req_i.tga, req_i.adr};

  // Priority search over the window table
  always_comb begin
    logic found;
    found = 1'b0;
    sel_o = '0;
    for (int i = 0; i < N_WINDOWS; i++) begin
      // Speaker split is left to the mux
      if (!found && WIN_SLAVE[i] != SLV_SPK &&
          (key & WINDOWS[i].mask) == WINDOWS[i].match) begin
        sel_o[WIN_SLAVE[i]] = 1'b1;
        found = 1'b1;
      end
    end
    hit_o = found;  // Low only for unmapped I/O
  end

endmodule

`default_nettype wire

/* verilog/wb_slave_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_slave_mux
  import bus_pkg::*, soc_map_pkg::*;
(
  input  wire                       rst_i,
  input  wb_req_t                   req_i,
  input  slave_sel_t                sel_i,
  input  wire                       hit_i,
  output wb_req_t [N_SLAVES-1:0]    slv_req_o,
  input  wb_rsp_t [N_SLAVES-1:0]    slv_rsp_i,
  output wb_rsp_t                   rsp_o
);

  logic [ADDR_W:0] key;
  logic            spk_hit;
  slave_sel_t      route;
  logic            def_ack;

  assign key = {req_i.tga, req_i.adr};

  // Port 61h high byte shares the keyboard window
  assign spk_hit = sel_i[SLV_KEYB] && req_i.sel[1] &&
                   ((key & WINDOWS[WIN_SPK].mask) == WINDOWS[WIN_SPK].match);

  always_comb begin
    route = sel_i;
    if (spk_hit) begin
      route[SLV_KEYB] = 1'b0;
      route[SLV_SPK]  = 1'b1;
    end
  end

  // Every slave sees the payload, only the routed one gets cyc/stb
  always_comb begin
    for (int k = 0; k < N_SLAVES; k++) begin
      slv_req_o[k]     = req_i;
      slv_req_o[k].cyc = req_i.cyc & route[k] & ~rst_i;
      slv_req_o[k].stb = req_i.stb & route[k] & ~rst_i;
    end
  end

  // Default responder, same-cycle ack
  assign def_ack = req_i.cyc & req_i.stb & ~hit_i;

  always_comb begin
    rsp_o.dat = '0;
    rsp_o.ack = def_ack;
    for (int k = 0; k < N_SLAVES; k++) begin
      if (route[k]) begin  // One-hot, at most one taken
        rsp_o.dat = slv_rsp_i[k].dat;
        rsp_o.ack = slv_rsp_i[k].ack;
      end
    end
  end

endmodule

`default_nettype wire
